/* all.f */
source/arm_pkg.sv
source/lane_packer.sv
source/frame_header.sv
source/report_ctrl.sv
source/report_sequencer.sv
source/arm_top.sv
verif/arm_checker.sv
verif/tb_arm.sv

/* verif/tb_arm.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_arm;

    localparam int RST_CYCLES     = 3;
    localparam int N_PACKETS      = 8;
    localparam int PKT_BOUND      = 40;
    localparam int N_WINDOWS      = 3;
    localparam int WINDOW_CYCLES  = 40;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + N_PACKETS * PKT_BOUND
                                    + N_WINDOWS * WINDOW_CYCLES + 100;

    logic                 clk;
    logic                 rst_n;
    logic                 report_pulse;
    logic                 test_start;
    logic                 ack;
    logic                 req;
    logic                 reg_rst;
    logic [7:0]           hdr_seq;
    logic [3:0]           gcl_seq;
    arm_pkg::stamp_t      timestamp;
    arm_pkg::slot_cycle_t slot_cycle;
    arm_pkg::tb_pair_t    tb_vals [arm_pkg::N_CHAN];
    arm_pkg::pkt_len_t    len_vals [arm_pkg::N_CHAN];
    arm_pkg::cnt_t        pgm_vals [arm_pkg::N_CHAN];
    arm_pkg::cnt_t        fsm_vals [arm_pkg::N_CHAN];
    arm_pkg::cnt_t        ssm_cnt;
    arm_pkg::beat_t       data;
    int                   err_cnt;
    int                   pkt_cnt;
    logic                 stop_bit;
    int                   tb_err;
    int                   test_base;
    int                   tests_run;
    int                   tests_failed;
    int                   ack_delay;
    int                   ack_wait;
    int                   cycle_cnt;
    logic [31:0]          lfsr_state;

    arm_top u_arm_top (
        .clk (clk), .rst_n (rst_n),
        .i_report_pulse (report_pulse), .i_test_start (test_start),
        .i_hdr_seq (hdr_seq), .i_gcl_seq (gcl_seq),
        .i_timestamp (timestamp), .i_slot_cycle (slot_cycle),
        .i_tb (tb_vals), .i_pkt_len (len_vals),
        .i_pgm_cnt (pgm_vals), .i_fsm_cnt (fsm_vals), .i_ssm_cnt (ssm_cnt),
        .i_ack (ack), .o_req (req), .o_data (data), .o_reg_rst (reg_rst)
    );

    arm_checker u_arm_checker (
        .clk (clk), .rst_n (rst_n), .i_test_start (test_start),
        .i_hdr_seq (hdr_seq), .i_gcl_seq (gcl_seq),
        .i_timestamp (timestamp), .i_slot_cycle (slot_cycle),
        .i_tb (tb_vals), .i_pkt_len (len_vals),
        .i_pgm_cnt (pgm_vals), .i_fsm_cnt (fsm_vals), .i_ssm_cnt (ssm_cnt),
        .i_req (req), .i_ack (ack), .i_data (data),
        .o_err_cnt (err_cnt), .o_pkt_cnt (pkt_cnt), .o_stop_bit (stop_bit)
    );

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic randomize_inputs();
        for (int ch = 0; ch < arm_pkg::N_CHAN; ch++) begin
            tb_vals[ch]  = lfsr_bits(32);
            len_vals[ch] = arm_pkg::pkt_len_t'(lfsr_bits(12));
            pgm_vals[ch] = lfsr_bits(32);
            fsm_vals[ch] = lfsr_bits(32);
        end
        timestamp[47:32] = 16'(lfsr_bits(16));
        timestamp[31:0]  = lfsr_bits(32);
        slot_cycle       = arm_pkg::slot_cycle_t'(lfsr_bits(20));
        hdr_seq          = 8'(lfsr_bits(8));
        gcl_seq          = 4'(lfsr_bits(4));
        ssm_cnt          = lfsr_bits(32);
        ack_delay        = int'(lfsr_bits(3));
    endtask

    task automatic send_pulse();
        @(negedge clk);
        report_pulse = 1'b1;
        @(negedge clk);
        report_pulse = 1'b0;
    endtask

    // pulse, then wait for the checker to count the packet
    task automatic run_packet();
        int base;
        base = pkt_cnt;
        send_pulse();
        while (pkt_cnt == base) begin
            @(negedge clk);
        end
    endtask

    task automatic watch_idle(input int cycles, output int req_seen, output int rst_low);
        req_seen = 0;
        rst_low  = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (req) req_seen++;
            if (!reg_rst) rst_low++;
        end
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d",
                     $time, what, actual, expected);
            tb_err++;
        end
    endtask

    task automatic close_test(input string name);
        int errs;
        errs = tb_err + err_cnt - test_base;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
        test_base = tb_err + err_cnt;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // multiplexer model, acks after ack_delay falling edges
    initial begin
        ack      = 1'b0;
        ack_wait = 0;
        forever begin
            @(negedge clk);
            if (req && !ack) begin
                if (ack_wait >= ack_delay) ack = 1'b1;
                else ack_wait++;
            end else begin
                ack      = 1'b0;
                ack_wait = 0;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin
        int base;
        int req_seen;
        int rst_low;
        rst_n        = 1'b0;
        report_pulse = 1'b0;
        test_start   = 1'b0;
        hdr_seq      = '0;
        gcl_seq      = '0;
        timestamp    = '0;
        slot_cycle   = '0;
        ssm_cnt      = '0;
        for (int ch = 0; ch < arm_pkg::N_CHAN; ch++) begin
            tb_vals[ch]  = '0;
            len_vals[ch] = '0;
            pgm_vals[ch] = '0;
            fsm_vals[ch] = '0;
        end
        lfsr_state   = 32'he29f_ff16;
        ack_delay    = 0;
        tb_err       = 0;
        test_base    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // no report while the test is idle
        randomize_inputs();
        base = pkt_cnt;
        repeat (3) send_pulse();
        watch_idle(WINDOW_CYCLES, req_seen, rst_low);
        check_value(pkt_cnt - base, 0, "packets before start");
        check_value(req_seen, 0, "o_req cycles before start");
        check_value(rst_low, 0, "o_reg_rst low cycles before start");
        close_test("pulses before start");

        @(negedge clk);
        test_start = 1'b1;
        @(negedge clk);
        check_value(reg_rst, 0, "o_reg_rst after start");
        randomize_inputs();
        run_packet();
        check_value(stop_bit, 0, "inverted start bit while running");
        close_test("start and first report");

        repeat (4) begin
            randomize_inputs();
            run_packet();
        end
        close_test("payload over random packets");

        // second pulse lands in the beat train
        randomize_inputs();
        base = pkt_cnt;
        send_pulse();
        while (!req) @(negedge clk);
        while (req) @(negedge clk);
        repeat (3) @(negedge clk);
        send_pulse();
        while (pkt_cnt == base) @(negedge clk);
        watch_idle(WINDOW_CYCLES, req_seen, rst_low);
        check_value(pkt_cnt - base, 1, "packets for pulse during packet");
        check_value(req_seen, 0, "o_req cycles after packet");
        close_test("pulse during packet");

        @(negedge clk);
        test_start = 1'b0;
        repeat (2) begin
            randomize_inputs();
            run_packet();
            check_value(stop_bit, 1, "inverted start bit after stop");
            check_value(reg_rst, 0, "o_reg_rst before third pulse");
        end
        base = pkt_cnt;
        send_pulse();
        watch_idle(WINDOW_CYCLES, req_seen, rst_low);
        check_value(pkt_cnt - base, 0, "packets for third pulse after stop");
        check_value(req_seen, 0, "o_req cycles after third pulse");
        check_value(reg_rst, 1, "o_reg_rst after third pulse");
        close_test("stop sequence");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 tb_err + err_cnt);
        if (tb_err + err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/arm_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_checker (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_test_start,
    input  wire [7:0]                 i_hdr_seq,
    input  wire [3:0]                 i_gcl_seq,
    input  wire arm_pkg::stamp_t      i_timestamp,
    input  wire arm_pkg::slot_cycle_t i_slot_cycle,
    input  wire arm_pkg::tb_pair_t    i_tb [arm_pkg::N_CHAN],
    input  wire arm_pkg::pkt_len_t    i_pkt_len [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t        i_pgm_cnt [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t        i_fsm_cnt [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t        i_ssm_cnt,
    input  wire                       i_req,
    input  wire                       i_ack,
    input  wire arm_pkg::beat_t       i_data,
    output int                        o_err_cnt,
    output int                        o_pkt_cnt,
    output logic                      o_stop_bit
);

    int                   beat_idx;
    logic                 accepted;
    logic                 req_q;
    arm_pkg::beat_t       exp_beat;
    logic                 snap_start;
    logic [7:0]           snap_hdr;
    logic [3:0]           snap_gcl;
    arm_pkg::stamp_t      snap_ts;
    arm_pkg::slot_cycle_t snap_slot;
    arm_pkg::tb_pair_t    snap_tb [arm_pkg::N_CHAN];
    arm_pkg::pkt_len_t    snap_len [arm_pkg::N_CHAN];
    arm_pkg::cnt_t        snap_pgm [arm_pkg::N_CHAN];
    arm_pkg::cnt_t        snap_fsm [arm_pkg::N_CHAN];
    arm_pkg::cnt_t        snap_ssm;

    // ******************************
    // reference beat
    // ******************************
    function automatic arm_pkg::beat_t expected_beat(input int idx);
        arm_pkg::beat_t b;
        int             ch;
        b      = '0;
        b.mark = arm_pkg::MARK_MID;
        case (idx)
            0: begin
                b.mark           = arm_pkg::MARK_FIRST;
                b.payload[96]    = 1'b1;
                b.payload[91:80] = 12'd288;
                b.payload[47:0]  = snap_ts;
            end
            2: b.payload = {48'hffff_ffff_ffff, 48'h0, 16'hff01, 4'h3, snap_gcl, snap_hdr};
            3: begin
                b.payload[91:80] = 12'd256;
                b.payload[47:0]  = snap_ts;
            end
            5: begin
                b.payload[32]   = ~snap_start;
                b.payload[19:0] = snap_slot;
            end
            // three buckets per beat, last group half empty
            6, 7, 8: begin
                for (int l = 0; l < 3; l++) begin
                    ch = (idx - 6) * 3 + l;
                    if (ch < arm_pkg::N_CHAN) begin
                        b.payload[l*32 +: 32] = snap_tb[ch];
                    end
                end
            end
            9: begin
                for (ch = 0; ch < arm_pkg::N_CHAN; ch++) begin
                    b.payload[ch*16 +: 12] = snap_len[ch] + 12'd4;
                end
            end
            11, 12: begin
                for (int l = 0; l < 4; l++) begin
                    b.payload[l*32 +: 32] = snap_pgm[(idx - 11) * 4 + l];
                end
            end
            14, 15: begin
                for (int l = 0; l < 4; l++) begin
                    b.payload[l*32 +: 32] = snap_fsm[(idx - 14) * 4 + l];
                end
            end
            17: begin
                b.mark           = arm_pkg::MARK_LAST;
                b.payload[31:0]  = snap_ssm;
            end
            default: b.payload = '0;
        endcase
        return b;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        o_err_cnt++;
    endtask

    initial begin
        o_err_cnt  = 0;
        o_pkt_cnt  = 0;
        o_stop_bit = 1'b0;
    end

    // ******************************
    // handshake and beat compare
    // ******************************
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx = -1;
            accepted = 1'b0;
            req_q    = 1'b0;
        end else begin
            if (accepted && i_req) begin
                report_mismatch("o_req still high after an accepted ack");
            end
            if (req_q && !accepted && !i_req) begin
                report_mismatch("o_req fell without an ack");
            end
            if (beat_idx < 0 && i_data.mark == arm_pkg::MARK_FIRST) begin
                if (!accepted) begin
                    report_mismatch("first beat without an accepted ack");
                end
                // inputs hold still for the whole packet
                snap_start = i_test_start;
                snap_hdr   = i_hdr_seq;
                snap_gcl   = i_gcl_seq;
                snap_ts    = i_timestamp;
                snap_slot  = i_slot_cycle;
                snap_tb    = i_tb;
                snap_len   = i_pkt_len;
                snap_pgm   = i_pgm_cnt;
                snap_fsm   = i_fsm_cnt;
                snap_ssm   = i_ssm_cnt;
                beat_idx   = 0;
            end else if (accepted) begin
                report_mismatch("no first beat after an accepted ack");
            end
            if (beat_idx >= 0) begin
                exp_beat = expected_beat(beat_idx);
                if (i_data !== exp_beat) begin
                    report_mismatch($sformatf("beat %0d expected %h got %h",
                                              beat_idx, exp_beat, i_data));
                end
                if (beat_idx == 5) begin
                    o_stop_bit = i_data.payload[32];
                end
                beat_idx++;
                if (beat_idx == arm_pkg::N_BEATS) begin
                    o_pkt_cnt++;
                    beat_idx = -1;
                end
            end else if (i_data !== '0) begin
                report_mismatch($sformatf("data %h outside a packet", i_data));
            end
            accepted = i_req && i_ack;
            req_q    = i_req;
        end
    end

endmodule

`default_nettype wire

/* source/arm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module arm_top (
    input  wire                    clk,
    input  wire                    rst_n,

    // test control
    input  wire                    i_report_pulse,
    input  wire                    i_test_start,

    // header fields
    input  wire [7:0]              i_hdr_seq,
    input  wire [3:0]              i_gcl_seq,
    input  wire arm_pkg::stamp_t   i_timestamp,
    input  wire arm_pkg::slot_cycle_t i_slot_cycle,

    // packet generator command array
    input  wire arm_pkg::tb_pair_t i_tb [arm_pkg::N_CHAN],
    input  wire arm_pkg::pkt_len_t i_pkt_len [arm_pkg::N_CHAN],

    // state arrays
    input  wire arm_pkg::cnt_t     i_pgm_cnt [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t     i_fsm_cnt [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t     i_ssm_cnt,

    // multiplexer exchange
    input  wire                    i_ack,
    output logic                   o_req,
    output arm_pkg::beat_t         o_data,

    // counter block register reset
    output logic                   o_reg_rst
);

    logic report_flag;

    // ******************************
    // test supervision
    // ******************************
    report_ctrl u_report_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_test_start   (i_test_start),
        .i_report_pulse (i_report_pulse),
        .o_report_flag  (report_flag),
        .o_reg_rst      (o_reg_rst)
    );

    // ******************************
    // report packet build
    // ******************************
    report_sequencer u_report_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_report_flag (report_flag),
        .i_ack         (i_ack),
        .i_test_start  (i_test_start),
        .i_slot_cycle  (i_slot_cycle),
        .i_hdr_seq     (i_hdr_seq),
        .i_gcl_seq     (i_gcl_seq),
        .i_timestamp   (i_timestamp),
        .i_tb          (i_tb),
        .i_pkt_len     (i_pkt_len),
        .i_pgm_cnt     (i_pgm_cnt),
        .i_fsm_cnt     (i_fsm_cnt),
        .i_ssm_cnt     (i_ssm_cnt),
        .o_req         (o_req),
        .o_data        (o_data)
    );

endmodule

`default_nettype wire

/* source/report_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module report_sequencer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  i_report_flag,
    input  wire                  i_ack,
    input  wire                  i_test_start,
    input  wire arm_pkg::slot_cycle_t i_slot_cycle,
    input  wire [7:0]            i_hdr_seq,
    input  wire [3:0]            i_gcl_seq,
    input  wire arm_pkg::stamp_t i_timestamp,
    input  wire arm_pkg::tb_pair_t i_tb [arm_pkg::N_CHAN],
    input  wire arm_pkg::pkt_len_t i_pkt_len [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t   i_pgm_cnt [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t   i_fsm_cnt [arm_pkg::N_CHAN],
    input  wire arm_pkg::cnt_t   i_ssm_cnt,
    output logic                 o_req,
    output arm_pkg::beat_t       o_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_SEND
    } seq_state_t;

    localparam logic [4:0] LAST_BEAT = 5'(arm_pkg::N_BEATS - 1);

    seq_state_t        state;
    logic [4:0]        beat_cnt;
    logic [4:0]        sel_idx;
    logic [1:0]        tb_group;
    logic [1:0]        cnt_group;
    logic [1:0]        next_mark;
    arm_pkg::payload_t next_payload;
    arm_pkg::payload_t hdr_payload;
    arm_pkg::payload_t tb_payload;
    arm_pkg::payload_t len_payload;
    arm_pkg::payload_t pgm_payload;
    arm_pkg::payload_t fsm_payload;

    // ******************************
    // beat sources
    // ******************************

    // beat 0 is built while waiting for the ack
    assign sel_idx = (state == ST_SEND) ? beat_cnt : 5'd0;

    always_comb begin
        tb_group  = 2'd0;
        cnt_group = 2'd0;
        case (sel_idx)
            5'd7:         tb_group  = 2'd1;
            5'd8:         tb_group  = 2'd2;
            5'd12, 5'd15: cnt_group = 2'd1;
            default:      cnt_group = 2'd0;
        endcase
    end

    frame_header u_frame_header (
        .i_index     (sel_idx[2:0]),
        .i_timestamp (i_timestamp),
        .i_hdr_seq   (i_hdr_seq),
        .i_gcl_seq   (i_gcl_seq),
        .o_payload   (hdr_payload)
    );

    lane_packer #(.T(arm_pkg::tb_pair_t), .ITEMS(arm_pkg::N_CHAN), .LANES(3)) u_tb_packer (
        .i_items   (i_tb),
        .i_group   (tb_group),
        .o_payload (tb_payload)
    );

    lane_packer #(.T(arm_pkg::cnt_t), .ITEMS(arm_pkg::N_CHAN), .LANES(4)) u_pgm_packer (
        .i_items   (i_pgm_cnt),
        .i_group   (cnt_group),
        .o_payload (pgm_payload)
    );

    lane_packer #(.T(arm_pkg::cnt_t), .ITEMS(arm_pkg::N_CHAN), .LANES(4)) u_fsm_packer (
        .i_items   (i_fsm_cnt),
        .i_group   (cnt_group),
        .o_payload (fsm_payload)
    );

    // lengths in 16-bit lanes, channel 1 lowest
    always_comb begin
        len_payload = '0;
        for (int ch = 0; ch < arm_pkg::N_CHAN; ch++) begin
            len_payload[ch*16 +: 12] = i_pkt_len[ch] + arm_pkg::LEN_ADJUST;
        end
    end

    // section select, separators fall to zero
    always_comb begin
        next_payload = '0;
        if (sel_idx < 5'(arm_pkg::N_HDR_BEATS)) begin
            next_payload = hdr_payload;
        end else begin
            case (sel_idx)
                5'd5: begin
                    next_payload[32]   = ~i_test_start;
                    next_payload[19:0] = i_slot_cycle;
                end
                5'd6, 5'd7, 5'd8: next_payload = tb_payload;
                5'd9:             next_payload = len_payload;
                5'd11, 5'd12:     next_payload = pgm_payload;
                5'd14, 5'd15:     next_payload = fsm_payload;
                5'd17:            next_payload[31:0] = i_ssm_cnt;
                default:          next_payload = '0;
            endcase
        end
    end

    assign next_mark = (sel_idx == 5'd0)      ? arm_pkg::MARK_FIRST :
                       (sel_idx == LAST_BEAT) ? arm_pkg::MARK_LAST  :
                                                arm_pkg::MARK_MID;

    // ******************************
    // req/ack and beat train
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            beat_cnt <= 5'd0;
            o_req    <= 1'b0;
            o_data   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    beat_cnt <= 5'd0;
                    o_data   <= '0;
                    if (i_report_flag) begin
                        o_req <= 1'b1;
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (i_ack) begin
                        o_req    <= 1'b0;
                        o_data   <= '{mark: next_mark, rsvd: 4'd0, payload: next_payload};
                        beat_cnt <= 5'd1;
                        state    <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    o_data   <= '{mark: next_mark, rsvd: 4'd0, payload: next_payload};
                    beat_cnt <= beat_cnt + 5'd1;
                    if (beat_cnt == LAST_BEAT) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    o_req <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_req_drop: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_req && i_ack) |=> !o_req
    ) else $error("request held after accepted ack");

    // a first beat opens a train of marked beats closed by the last one
    a_beat_marked: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_data.mark == arm_pkg::MARK_FIRST) |=>
            (o_data.mark == arm_pkg::MARK_MID) [*(arm_pkg::N_BEATS - 2)]
            ##1 (o_data.mark == arm_pkg::MARK_LAST)
    ) else $error("beat train with a missing or wrong marker");

endmodule

`default_nettype wire

/* source/report_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module report_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  i_test_start,
    input  wire  i_report_pulse,
    output logic o_report_flag,
    output logic o_reg_rst
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REPORT,
        ST_FIRST_AFTER_STOP,
        ST_SECOND_AFTER_STOP,
        ST_RESET_WAIT
    } ctrl_state_t;

    ctrl_state_t state;

    // ******************************
    // test supervision FSM
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            o_report_flag <= 1'b0;
            o_reg_rst     <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    o_report_flag <= 1'b0;
                    // counters leave reset with the test start
                    o_reg_rst <= ~i_test_start;
                    if (i_test_start) begin
                        state <= ST_REPORT;
                    end
                end
                ST_REPORT: begin
                    o_report_flag <= i_report_pulse;
                    if (!i_test_start) begin
                        state <= ST_FIRST_AFTER_STOP;
                    end
                end
                ST_FIRST_AFTER_STOP: begin
                    o_report_flag <= i_report_pulse;
                    if (i_report_pulse) begin
                        state <= ST_SECOND_AFTER_STOP;
                    end
                end
                ST_SECOND_AFTER_STOP: begin
                    o_report_flag <= i_report_pulse;
                    if (i_report_pulse) begin
                        state <= ST_RESET_WAIT;
                    end
                end
                ST_RESET_WAIT: begin
                    // third pulse resets the counters, no report
                    o_report_flag <= 1'b0;
                    if (i_report_pulse) begin
                        o_reg_rst <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: begin
                    o_report_flag <= 1'b0;
                    state         <= ST_IDLE;
                end
            endcase
        end
    end

    // reports only leave the block while the counters run
    a_flag_while_running: assert property (
        @(posedge clk) disable iff (!rst_n)
        o_report_flag |-> !o_reg_rst
    ) else $error("report flag raised while counter reset held");

endmodule

`default_nettype wire

/* source/frame_header.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_header (
    input  wire [2:0]            i_index,
    input  wire arm_pkg::stamp_t i_timestamp,
    input  wire [7:0]            i_hdr_seq,
    input  wire [3:0]            i_gcl_seq,
    output arm_pkg::payload_t    o_payload
);

    // ******************************
    // header beats 0 to 4
    // ******************************
    always_comb begin
        o_payload = '0;
        case (i_index)
            // outer metadata 0
            3'd0: begin
                o_payload[96]    = 1'b1;
                o_payload[91:80] = arm_pkg::OUTER_LEN;
                o_payload[47:0]  = i_timestamp;
            end
            // ethernet header, broadcast destination
            3'd2: begin
                o_payload[127:80] = '1;
                o_payload[79:32]  = '0;
                o_payload[31:16]  = arm_pkg::ETH_TYPE;
                o_payload[15:12]  = 4'h3;
                o_payload[11:0]   = {i_gcl_seq, i_hdr_seq};
            end
            // encapsulated metadata 0
            3'd3: begin
                o_payload[91:80] = arm_pkg::INNER_LEN;
                o_payload[47:0]  = i_timestamp;
            end
            // metadata 1 beats stay zero
            default: begin
                o_payload = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/lane_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_packer #(
    parameter type T     = logic [31:0],
    parameter int  ITEMS = 8,
    parameter int  LANES = 4
) (
    input  wire T             i_items [ITEMS],
    input  wire [1:0]         i_group,
    output arm_pkg::payload_t o_payload
);

    // lane width follows the item type
    localparam int W = $bits(T);

    // ******************************
    // group to lane mapping
    // ******************************
    always_comb begin
        int base;
        base      = int'(i_group) * LANES;
        o_payload = '0;
        for (int l = 0; l < LANES; l++) begin
            // lanes past the last item stay zero
            if (base + l < ITEMS) begin
                o_payload[l*W +: W] = i_items[base + l];
            end
        end
    end

endmodule

`default_nettype wire

/* source/arm_pkg.sv */
`default_nettype none

package arm_pkg;

    // ******************************
    // beat format
    // ******************************

    // payload field of every beat
    typedef logic [127:0] payload_t;

    // one output beat, 134 bits wide
    typedef struct packed {
        logic [1:0] mark;
        logic [3:0] rsvd;
        payload_t   payload;
    } beat_t;

    // position markers, 00 means no beat
    localparam logic [1:0] MARK_FIRST = 2'b01;
    localparam logic [1:0] MARK_MID   = 2'b11;
    localparam logic [1:0] MARK_LAST  = 2'b10;

    // ******************************
    // report items
    // ******************************

    // token bucket, size in [31:16], rate in [15:0]
    typedef logic [31:0] tb_pair_t;

    typedef logic [11:0] pkt_len_t;

    typedef logic [31:0] cnt_t;

    typedef logic [47:0] stamp_t;

    // gate control time slot cycle
    typedef logic [19:0] slot_cycle_t;

    // ******************************
    // packet layout
    // ******************************

    localparam int N_CHAN      = 8;
    localparam int N_BEATS     = 18;
    localparam int N_HDR_BEATS = 5;

    // lengths in bytes, 16 bytes per beat
    localparam logic [11:0] OUTER_LEN = 12'd288;
    localparam logic [11:0] INNER_LEN = 12'd256;

    // added to each reported packet length
    localparam logic [11:0] LEN_ADJUST = 12'd4;

    localparam logic [15:0] ETH_TYPE = 16'hff01;

endpackage

`default_nettype wire
